/* sources.f */
+incdir+include
design/cpu_isa_pkg.sv
design/ctrl_sig_pkg.sv
design/opcode_decoder.sv
design/cycle_sequencer.sv
design/control_generator.sv
design/cpu_controller.sv
verification/cpu_controller_tb.sv

/* include/isa_ref_table.svh */
`ifndef ISA_REF_TABLE_SVH
`define ISA_REF_TABLE_SVH

// Instruction classes as seen by the checks
typedef enum logic [2:0] {
  RC_LOAD, RC_STORE, RC_XFER, RC_ALU, RC_RMW, RC_FLAG, RC_JMP, RC_NOP
} ref_class_t;

typedef struct packed {
  logic [7:0]              opcode;
  ref_class_t              cls;
  cpu_isa_pkg::addr_mode_t mode;
  logic [2:0]              len;
} ref_entry_t;

localparam int ISA_REF_SIZE = 29;

// Cycles from one opcode fetch to the next with RDY high
localparam ref_entry_t ISA_REF [ISA_REF_SIZE] = '{
  '{8'hA9, RC_LOAD,  cpu_isa_pkg::AM_IMM, 3'd2},
  '{8'hA6, RC_LOAD,  cpu_isa_pkg::AM_ZPG, 3'd3},
  '{8'hAC, RC_LOAD,  cpu_isa_pkg::AM_ABS, 3'd4},
  '{8'h85, RC_STORE, cpu_isa_pkg::AM_ZPG, 3'd3},
  '{8'h8E, RC_STORE, cpu_isa_pkg::AM_ABS, 3'd4},
  '{8'h8C, RC_STORE, cpu_isa_pkg::AM_ABS, 3'd4},
  '{8'hAA, RC_XFER,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h98, RC_XFER,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'hBA, RC_XFER,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h9A, RC_XFER,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h69, RC_ALU,   cpu_isa_pkg::AM_IMM, 3'd2},
  '{8'hE5, RC_ALU,   cpu_isa_pkg::AM_ZPG, 3'd3},
  '{8'h2D, RC_ALU,   cpu_isa_pkg::AM_ABS, 3'd4},
  '{8'hC9, RC_ALU,   cpu_isa_pkg::AM_IMM, 3'd2},
  '{8'hEC, RC_ALU,   cpu_isa_pkg::AM_ABS, 3'd4},
  '{8'h24, RC_ALU,   cpu_isa_pkg::AM_ZPG, 3'd3},
  '{8'hE8, RC_ALU,   cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h88, RC_ALU,   cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h0A, RC_RMW,   cpu_isa_pkg::AM_ACC, 3'd2},
  '{8'h46, RC_RMW,   cpu_isa_pkg::AM_ZPG, 3'd5},
  '{8'h2E, RC_RMW,   cpu_isa_pkg::AM_ABS, 3'd6},
  '{8'hE6, RC_RMW,   cpu_isa_pkg::AM_ZPG, 3'd5},
  '{8'h18, RC_FLAG,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'hF8, RC_FLAG,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'hB8, RC_FLAG,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h78, RC_FLAG,  cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h4C, RC_JMP,   cpu_isa_pkg::AM_ABS, 3'd3},
  '{8'hEA, RC_NOP,   cpu_isa_pkg::AM_IMP, 3'd2},
  '{8'h02, RC_NOP,   cpu_isa_pkg::AM_IMP, 3'd2}
};

`endif

/* verification/cpu_controller_tb.sv */
`timescale 1ns/10ps

module cpu_controller_tb;

  `include "isa_ref_table.svh"

  localparam int NUM_INSTR  = 200;
  localparam int NUM_STALLS = 64;

  logic                    CLK;
  logic                    reset;
  logic                    RDY;
  logic [7:0]              INSTR;
  logic                    IR_WE;
  ctrl_sig_pkg::bus_ctrl_t bus;
  ctrl_sig_pkg::alu_ctrl_t alu;
  ctrl_sig_pkg::reg_ctrl_t regs;
  ctrl_sig_pkg::pc_ctrl_t  pc;
  ctrl_sig_pkg::ab_ctrl_t  ab;

  logic [31:0] rng_state;
  ref_entry_t  cur;
  int          run_len;
  int          write_cnt;
  int          fetch_cnt;
  int          cycle_cnt;
  int          cycle_limit = 0;
  int          gap_len [NUM_STALLS];
  int          stall_len [NUM_STALLS];
  logic        len_valid;
  logic        load_next;
  logic        prev_low;
  logic [40:0] out_vec;
  logic [40:0] prev_vec;

  cpu_controller cpu_controller_i (
    .CLK   (CLK),
    .reset (reset),
    .RDY   (RDY),
    .INSTR (INSTR),
    .IR_WE (IR_WE),
    .bus   (bus),
    .alu   (alu),
    .regs  (regs),
    .pc    (pc),
    .ab    (ab)
  );

  assign out_vec = {IR_WE, bus, alu, regs, pc, ab};

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int random_below(input int n);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % n);
  endfunction

  // Register enables in T0 as {a, x, y, s}
  function automatic logic [3:0] writeback_regs(input logic [7:0] opcode);
    case (opcode)
      8'hA9, 8'h98, 8'h69, 8'hE5, 8'h2D, 8'hC9, 8'h24, 8'h0A: return 4'b1000;
      8'hA6, 8'hAA, 8'hBA, 8'hEC, 8'hE8: return 4'b0100;
      8'hAC, 8'h88: return 4'b0010;
      8'h9A: return 4'b0001;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic ctrl_sig_pkg::alu_src_a_t move_source(input logic [7:0] opcode);
    case (opcode)
      8'hAA: return ctrl_sig_pkg::SRC_A_A;
      8'h98: return ctrl_sig_pkg::SRC_A_Y;
      8'hBA: return ctrl_sig_pkg::SRC_A_S;
      8'h9A: return ctrl_sig_pkg::SRC_A_X;
      default: return ctrl_sig_pkg::SRC_A_T;
    endcase
  endfunction

  function automatic ctrl_sig_pkg::db_src_t store_source(input logic [7:0] opcode);
    case (opcode)
      8'h85: return ctrl_sig_pkg::DB_A;
      8'h8E: return ctrl_sig_pkg::DB_X;
      8'h8C: return ctrl_sig_pkg::DB_Y;
      default: return ctrl_sig_pkg::DB_T;
    endcase
  endfunction

  function automatic int writes_per_instr(input ref_entry_t e);
    if (e.cls == RC_STORE)
      return 1;
    if (e.cls == RC_RMW && e.mode != cpu_isa_pkg::AM_ACC)
      return 2;
    return 0;
  endfunction

  function automatic ctrl_sig_pkg::p_src_t status_source(input ref_entry_t e);
    if (e.cls == RC_ALU || (e.cls == RC_RMW && e.mode == cpu_isa_pkg::AM_ACC))
      return ctrl_sig_pkg::P_ALU;
    if (e.opcode inside {8'h18, 8'hB8})
      return ctrl_sig_pkg::P_CLR;
    if (e.opcode inside {8'hF8, 8'h78})
      return ctrl_sig_pkg::P_SET;
    return ctrl_sig_pkg::P_NON;
  endfunction

  // C, D, V and I bit positions of the status register
  function automatic logic [7:0] status_mask(input logic [7:0] opcode);
    case (opcode)
      8'h18: return 8'h01;
      8'hF8: return 8'h08;
      8'hB8: return 8'h40;
      8'h78: return 8'h04;
      default: return 8'h00;
    endcase
  endfunction

  task automatic fail_value(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    $display("error: %s expected %0h actual %0h", name, expected, actual);
    $display("*** FAILED ***");
    $fatal(1, "check %s failed", name);
  endtask

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Bookkeeping per instruction, counted on ready cycles only
  always @(posedge CLK) begin
    if (reset) begin
      run_len   <= 0;
      write_cnt <= 0;
      len_valid <= 1'b0;
      load_next <= 1'b0;
      prev_low  <= 1'b0;
    end else begin
      load_next <= IR_WE && RDY;
      prev_low  <= !RDY;
      if (RDY && IR_WE) begin
        run_len   <= 1;
        write_cnt <= 0;
        len_valid <= 1'b1;
      end else if (RDY) begin
        run_len <= run_len + 1;
        if (bus.r_w == ctrl_sig_pkg::RW_WRITE)
          write_cnt <= write_cnt + 1;
      end
    end
    prev_vec <= out_vec;
  end

  a_length: assert property (@(posedge CLK) disable iff (reset)
    IR_WE && RDY && len_valid |-> run_len == cur.len)
    else fail_value("instruction length", $sampled(cur.len), $sampled(run_len));

  a_writeback: assert property (@(posedge CLK) disable iff (reset)
    IR_WE |-> {regs.a_we, regs.x_we, regs.y_we, regs.s_we} == writeback_regs(cur.opcode))
    else fail_value("writeback enables", writeback_regs($sampled(cur.opcode)),
                    $sampled({regs.a_we, regs.x_we, regs.y_we, regs.s_we}));

  a_move_src: assert property (@(posedge CLK) disable iff (reset)
    IR_WE && cur.cls inside {RC_LOAD, RC_XFER} |->
      alu.alu_op == ctrl_sig_pkg::ALU_THA && alu.alu_src_a == move_source(cur.opcode))
    else fail_value("move source", {ctrl_sig_pkg::ALU_THA, move_source($sampled(cur.opcode))},
                    $sampled({alu.alu_op, alu.alu_src_a}));

  a_alu_dest: assert property (@(posedge CLK) disable iff (reset)
    IR_WE && !(cur.cls inside {RC_LOAD, RC_XFER}) && writeback_regs(cur.opcode) != 4'b0000
      |-> regs.reg_src == ctrl_sig_pkg::REG_SRC_ALU)
    else fail_value("writeback source", ctrl_sig_pkg::REG_SRC_ALU, $sampled(regs.reg_src));

  a_status: assert property (@(posedge CLK) disable iff (reset)
    IR_WE |-> regs.p_src == status_source(cur))
    else fail_value("status source", status_source($sampled(cur)), $sampled(regs.p_src));

  a_flag_mask: assert property (@(posedge CLK) disable iff (reset)
    IR_WE && cur.cls == RC_FLAG |-> regs.p_mask == status_mask(cur.opcode))
    else fail_value("flag mask", status_mask($sampled(cur.opcode)), $sampled(regs.p_mask));

  a_fetch_read: assert property (@(posedge CLK) disable iff (reset)
    IR_WE |-> bus.r_w == ctrl_sig_pkg::RW_READ)
    else fail_value("fetch bus direction", ctrl_sig_pkg::RW_READ, $sampled(bus.r_w));

  a_write_count: assert property (@(posedge CLK) disable iff (reset)
    IR_WE && RDY && len_valid |-> write_cnt == writes_per_instr(cur))
    else fail_value("memory write count", writes_per_instr($sampled(cur)), $sampled(write_cnt));

  // Stores on every write, read-modify-write on its second write
  a_write_data: assert property (@(posedge CLK) disable iff (reset)
    bus.r_w == ctrl_sig_pkg::RW_WRITE &&
      (cur.cls == RC_STORE || (cur.cls == RC_RMW && write_cnt == 1))
      |-> bus.db_out_src == store_source(cur.opcode))
    else fail_value("write data source", store_source($sampled(cur.opcode)),
                    $sampled(bus.db_out_src));

  a_jmp_target: assert property (@(posedge CLK) disable iff (reset)
    cur.cls == RC_JMP && !IR_WE && run_len == 2 |->
      {pc.pcl_src, pc.pch_src, pc.pcl_we, pc.pch_we, ab.abl_src, ab.abh_src} ==
      {ctrl_sig_pkg::PCL_T, ctrl_sig_pkg::PCH_MEM, 2'b11, ctrl_sig_pkg::AB_T,
       ctrl_sig_pkg::AB_MEM})
    else fail_value("jmp target",
                    {ctrl_sig_pkg::PCL_T, ctrl_sig_pkg::PCH_MEM, 2'b11, ctrl_sig_pkg::AB_T,
                     ctrl_sig_pkg::AB_MEM},
                    $sampled({pc.pcl_src, pc.pch_src, pc.pcl_we, pc.pch_we,
                              ab.abl_src, ab.abh_src}));

  a_stall: assert property (@(posedge CLK) disable iff (reset)
    prev_low |-> out_vec == prev_vec)
    else fail_value("stall hold", $sampled(prev_vec), $sampled(out_vec));

  a_reset_fetch: assert property (@(posedge CLK)
    $fell(reset) |-> IR_WE && bus.r_w == ctrl_sig_pkg::RW_READ)
    else fail_value("first cycle after reset", {1'b1, ctrl_sig_pkg::RW_READ},
                    $sampled({IR_WE, bus.r_w}));

  initial begin
    wait (cycle_limit > 0);
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: no end of run within %0d cycles", cycle_limit);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    int i;
    int pick;
    int stall_total;
    int next_stall;
    int gap_left;
    int low_left;
    rng_state = 32'd48131;
    reset     = 1'b1;
    RDY       = 1'b1;
    // Register holds a NOP out of reset
    cur       = ISA_REF[ISA_REF_SIZE - 2];
    INSTR     = cur.opcode;
    fetch_cnt = 0;
    stall_total = 0;
    for (i = 0; i < NUM_STALLS; i++) begin
      gap_len[i]   = 1 + random_below(8);
      stall_len[i] = 1 + random_below(3);
      stall_total  = stall_total + stall_len[i];
    end
    cycle_limit = NUM_INSTR * 6 + stall_total + 20;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    reset      = 1'b0;
    next_stall = 0;
    gap_left   = gap_len[0];
    low_left   = 0;
    while (fetch_cnt <= NUM_INSTR) begin
      // Instruction register loads after a ready fetch cycle
      if (load_next) begin
        pick  = random_below(ISA_REF_SIZE);
        cur   = ISA_REF[pick];
        INSTR = cur.opcode;
        fetch_cnt++;
      end
      if (low_left > 0) begin
        RDY = 1'b0;
        low_left--;
      end else if (gap_left == 0 && next_stall < NUM_STALLS) begin
        RDY      = 1'b0;
        low_left = stall_len[next_stall] - 1;
        next_stall++;
        if (next_stall < NUM_STALLS)
          gap_left = gap_len[next_stall];
      end else begin
        RDY = 1'b1;
        if (gap_left > 0)
          gap_left--;
      end
      @(negedge CLK);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* design/cpu_controller.sv */
`timescale 1ns/10ps

module cpu_controller (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    RDY,
  input  logic [7:0]              INSTR,
  output logic                    IR_WE,
  output ctrl_sig_pkg::bus_ctrl_t bus,
  output ctrl_sig_pkg::alu_ctrl_t alu,
  output ctrl_sig_pkg::reg_ctrl_t regs,
  output ctrl_sig_pkg::pc_ctrl_t  pc,
  output ctrl_sig_pkg::ab_ctrl_t  ab
);

  cpu_isa_pkg::decoded_instr_t dec;
  ctrl_sig_pkg::state_t        state;

  opcode_decoder opcode_decoder_i (
    .instr (INSTR),
    .dec   (dec)
  );

  cycle_sequencer cycle_sequencer_i (
    .CLK   (CLK),
    .reset (reset),
    .rdy   (RDY),
    .dec   (dec),
    .state (state)
  );

  control_generator control_generator_i (
    .state (state),
    .dec   (dec),
    .ir_we (IR_WE),
    .bus   (bus),
    .alu   (alu),
    .regs  (regs),
    .pc    (pc),
    .ab    (ab)
  );

endmodule

/* design/control_generator.sv */
`timescale 1ns/10ps

module control_generator (
  input  ctrl_sig_pkg::state_t        state,
  input  cpu_isa_pkg::decoded_instr_t dec,
  output logic                        ir_we,
  output ctrl_sig_pkg::bus_ctrl_t     bus,
  output ctrl_sig_pkg::alu_ctrl_t     alu,
  output ctrl_sig_pkg::reg_ctrl_t     regs,
  output ctrl_sig_pkg::pc_ctrl_t      pc,
  output ctrl_sig_pkg::ab_ctrl_t      ab
);

  typedef struct packed {
    ctrl_sig_pkg::reg_sel_t src;
    ctrl_sig_pkg::reg_sel_t dst;
  } mov_t;

  typedef struct packed {
    ctrl_sig_pkg::alu_op_t    op;
    ctrl_sig_pkg::alu_src_a_t src_a;
  } exe_t;

  mov_t                     mov;
  exe_t                     exe;
  ctrl_sig_pkg::alu_src_a_t shift_src;
  logic [7:0]               flag_mask;
  logic                     exe_writes;

  // Loads take the operand from T
  always_comb begin
    mov = '{ctrl_sig_pkg::REG_T, ctrl_sig_pkg::REG_T};
    case (dec.op)
      cpu_isa_pkg::OP_LDA: mov = '{ctrl_sig_pkg::REG_T, ctrl_sig_pkg::REG_A};
      cpu_isa_pkg::OP_LDX: mov = '{ctrl_sig_pkg::REG_T, ctrl_sig_pkg::REG_X};
      cpu_isa_pkg::OP_LDY: mov = '{ctrl_sig_pkg::REG_T, ctrl_sig_pkg::REG_Y};
      cpu_isa_pkg::OP_TAX: mov = '{ctrl_sig_pkg::REG_A, ctrl_sig_pkg::REG_X};
      cpu_isa_pkg::OP_TAY: mov = '{ctrl_sig_pkg::REG_A, ctrl_sig_pkg::REG_Y};
      cpu_isa_pkg::OP_TXA: mov = '{ctrl_sig_pkg::REG_X, ctrl_sig_pkg::REG_A};
      cpu_isa_pkg::OP_TYA: mov = '{ctrl_sig_pkg::REG_Y, ctrl_sig_pkg::REG_A};
      cpu_isa_pkg::OP_TSX: mov = '{ctrl_sig_pkg::REG_S, ctrl_sig_pkg::REG_X};
      cpu_isa_pkg::OP_TXS: mov = '{ctrl_sig_pkg::REG_X, ctrl_sig_pkg::REG_S};
      default: ;
    endcase
  end

  // Shifts act on A in accumulator mode, on T for memory
  assign shift_src = (dec.addr_mode == cpu_isa_pkg::AM_ACC) ? ctrl_sig_pkg::SRC_A_A
                                                            : ctrl_sig_pkg::SRC_A_T;

  always_comb begin
    exe = '{ctrl_sig_pkg::ALU_THA, ctrl_sig_pkg::SRC_A_A};
    case (dec.op)
      cpu_isa_pkg::OP_ADC: exe = '{ctrl_sig_pkg::ALU_ADC, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_SBC: exe = '{ctrl_sig_pkg::ALU_SBC, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_AND: exe = '{ctrl_sig_pkg::ALU_AND, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_ORA: exe = '{ctrl_sig_pkg::ALU_ORA, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_EOR: exe = '{ctrl_sig_pkg::ALU_EOR, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_CMP: exe = '{ctrl_sig_pkg::ALU_CMP, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_CPX: exe = '{ctrl_sig_pkg::ALU_CMP, ctrl_sig_pkg::SRC_A_X};
      cpu_isa_pkg::OP_CPY: exe = '{ctrl_sig_pkg::ALU_CMP, ctrl_sig_pkg::SRC_A_Y};
      cpu_isa_pkg::OP_BIT: exe = '{ctrl_sig_pkg::ALU_BIT, ctrl_sig_pkg::SRC_A_A};
      cpu_isa_pkg::OP_INX: exe = '{ctrl_sig_pkg::ALU_INC, ctrl_sig_pkg::SRC_A_X};
      cpu_isa_pkg::OP_INY: exe = '{ctrl_sig_pkg::ALU_INC, ctrl_sig_pkg::SRC_A_Y};
      cpu_isa_pkg::OP_DEX: exe = '{ctrl_sig_pkg::ALU_DEC, ctrl_sig_pkg::SRC_A_X};
      cpu_isa_pkg::OP_DEY: exe = '{ctrl_sig_pkg::ALU_DEC, ctrl_sig_pkg::SRC_A_Y};
      cpu_isa_pkg::OP_INC: exe = '{ctrl_sig_pkg::ALU_INC, ctrl_sig_pkg::SRC_A_T};
      cpu_isa_pkg::OP_DEC: exe = '{ctrl_sig_pkg::ALU_DEC, ctrl_sig_pkg::SRC_A_T};
      cpu_isa_pkg::OP_ASL: exe = '{ctrl_sig_pkg::ALU_ASL, shift_src};
      cpu_isa_pkg::OP_LSR: exe = '{ctrl_sig_pkg::ALU_LSR, shift_src};
      cpu_isa_pkg::OP_ROL: exe = '{ctrl_sig_pkg::ALU_ROL, shift_src};
      cpu_isa_pkg::OP_ROR: exe = '{ctrl_sig_pkg::ALU_ROR, shift_src};
      default: ;
    endcase
  end

  always_comb begin
    case (dec.op)
      cpu_isa_pkg::OP_CLC, cpu_isa_pkg::OP_SEC: flag_mask = cpu_isa_pkg::FLAG_MASK_C;
      cpu_isa_pkg::OP_CLD, cpu_isa_pkg::OP_SED: flag_mask = cpu_isa_pkg::FLAG_MASK_D;
      cpu_isa_pkg::OP_CLI, cpu_isa_pkg::OP_SEI: flag_mask = cpu_isa_pkg::FLAG_MASK_I;
      cpu_isa_pkg::OP_CLV:                      flag_mask = cpu_isa_pkg::FLAG_MASK_V;
      default:                                  flag_mask = 8'h00;
    endcase
  end

  // Memory RMW results go back through T, not a register
  assign exe_writes = (exe.op != ctrl_sig_pkg::ALU_THA) && (exe.src_a != ctrl_sig_pkg::SRC_A_T);

  always_comb begin
    ir_we = 1'b0;
    bus   = '{ctrl_sig_pkg::RW_READ, ctrl_sig_pkg::DB_A};
    alu   = '{ctrl_sig_pkg::ALU_THA, ctrl_sig_pkg::SRC_A_A, ctrl_sig_pkg::SRC_B_T};
    regs  = '{ctrl_sig_pkg::REG_SRC_MEM, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
              ctrl_sig_pkg::P_NON, 8'h00};
    pc    = '{ctrl_sig_pkg::PC_NOP, ctrl_sig_pkg::PCL_ADD, ctrl_sig_pkg::PCH_ADD, 1'b0, 1'b0};
    ab    = '{ctrl_sig_pkg::AB_PCN, ctrl_sig_pkg::AB_PCN, 1'b0, 1'b0};
    case (state)
      ctrl_sig_pkg::T0_R_OPCO: begin
        // Fetch the next opcode while the current one writes back
        ir_we          = 1'b1;
        alu.alu_op     = exe.op;
        alu.alu_src_a  = exe.src_a;
        regs.reg_src   = ctrl_sig_pkg::REG_SRC_ALU;
        if (dec.is_load || dec.is_transfer) begin
          // Moves pass the source through the ALU unchanged
          alu.alu_op    = ctrl_sig_pkg::ALU_THA;
          alu.alu_src_a = ctrl_sig_pkg::alu_src_a_t'(mov.src);
          regs.a_we     = mov.dst == ctrl_sig_pkg::REG_A;
          regs.x_we     = mov.dst == ctrl_sig_pkg::REG_X;
          regs.y_we     = mov.dst == ctrl_sig_pkg::REG_Y;
          regs.s_we     = mov.dst == ctrl_sig_pkg::REG_S;
        end else if (exe_writes) begin
          regs.a_we = exe.src_a == ctrl_sig_pkg::SRC_A_A;
          regs.x_we = exe.src_a == ctrl_sig_pkg::SRC_A_X;
          regs.y_we = exe.src_a == ctrl_sig_pkg::SRC_A_Y;
          regs.s_we = exe.src_a == ctrl_sig_pkg::SRC_A_S;
        end
        regs.p_mask = flag_mask;
        if (dec.is_set)
          regs.p_src = ctrl_sig_pkg::P_SET;
        else if (dec.is_clr)
          regs.p_src = ctrl_sig_pkg::P_CLR;
        else if (exe_writes)
          regs.p_src = ctrl_sig_pkg::P_ALU;
        pc = '{ctrl_sig_pkg::PC_INC, ctrl_sig_pkg::PCL_ADD, ctrl_sig_pkg::PCH_ADD, 1'b1, 1'b1};
        ab = '{ctrl_sig_pkg::AB_PCN, ctrl_sig_pkg::AB_PCN, 1'b1, 1'b1};
      end
      ctrl_sig_pkg::T1_R_OPER: begin
        regs.t_we = 1'b1;
        if (dec.addr_mode != cpu_isa_pkg::AM_IMP)
          pc.pc_add = ctrl_sig_pkg::PC_INC;
        pc.pcl_we = 1'b1;
        pc.pch_we = 1'b1;
        // Zero page operand addresses page 00
        if (dec.addr_mode == cpu_isa_pkg::AM_ZPG)
          ab = '{ctrl_sig_pkg::AB_MEM, ctrl_sig_pkg::AB_H00, 1'b1, 1'b1};
        else
          ab = '{ctrl_sig_pkg::AB_PCN, ctrl_sig_pkg::AB_PCN, 1'b1, 1'b1};
      end
      ctrl_sig_pkg::T2_ABS_AM: begin
        pc = '{ctrl_sig_pkg::PC_INC, ctrl_sig_pkg::PCL_ADD, ctrl_sig_pkg::PCH_ADD, 1'b1, 1'b1};
        if (dec.op == cpu_isa_pkg::OP_JMP) begin
          pc.pcl_src = ctrl_sig_pkg::PCL_T;
          pc.pch_src = ctrl_sig_pkg::PCH_MEM;
        end
        ab = '{ctrl_sig_pkg::AB_T, ctrl_sig_pkg::AB_MEM, 1'b1, 1'b1};
      end
      ctrl_sig_pkg::TX_R_DATA: begin
        regs.t_we = 1'b1;
        // RMW keeps the operand address for the write cycles
        if (!dec.is_rmw)
          ab = '{ctrl_sig_pkg::AB_PCC, ctrl_sig_pkg::AB_PCC, 1'b1, 1'b1};
      end
      ctrl_sig_pkg::TX_M_DATA: begin
        bus           = '{ctrl_sig_pkg::RW_WRITE, ctrl_sig_pkg::DB_T};
        alu.alu_op    = exe.op;
        alu.alu_src_a = exe.src_a;
        regs.reg_src  = ctrl_sig_pkg::REG_SRC_ALU;
        regs.t_we     = 1'b1;
        regs.p_src    = ctrl_sig_pkg::P_ALU;
      end
      ctrl_sig_pkg::TX_W_DATA: begin
        bus.r_w = ctrl_sig_pkg::RW_WRITE;
        case (dec.op)
          cpu_isa_pkg::OP_STA: bus.db_out_src = ctrl_sig_pkg::DB_A;
          cpu_isa_pkg::OP_STX: bus.db_out_src = ctrl_sig_pkg::DB_X;
          cpu_isa_pkg::OP_STY: bus.db_out_src = ctrl_sig_pkg::DB_Y;
          default:             bus.db_out_src = ctrl_sig_pkg::DB_T;
        endcase
        ab = '{ctrl_sig_pkg::AB_PCC, ctrl_sig_pkg::AB_PCC, 1'b1, 1'b1};
      end
      default: ;
    endcase
  end

  // Move and execute paths must never both claim a register
  always_comb begin
    a_one_reg_we: assert final ($onehot0({regs.a_we, regs.x_we, regs.y_we, regs.s_we}));
  end

endmodule

/* design/cycle_sequencer.sv */
`timescale 1ns/10ps

module cycle_sequencer (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        rdy,
  input  cpu_isa_pkg::decoded_instr_t dec,
  output ctrl_sig_pkg::state_t        state
);

  ctrl_sig_pkg::state_t next_state;

  // Timing state only advances on ready cycles
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= ctrl_sig_pkg::T0_R_OPCO;
    end else if (rdy) begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = ctrl_sig_pkg::T0_R_OPCO;
    case (state)
      ctrl_sig_pkg::T0_R_OPCO: next_state = ctrl_sig_pkg::T1_R_OPER;
      ctrl_sig_pkg::T1_R_OPER: begin
        // Single-byte and immediate forms finish here
        if (dec.addr_mode == cpu_isa_pkg::AM_ZPG)
          next_state = dec.is_store ? ctrl_sig_pkg::TX_W_DATA : ctrl_sig_pkg::TX_R_DATA;
        else if (dec.addr_mode == cpu_isa_pkg::AM_ABS)
          next_state = ctrl_sig_pkg::T2_ABS_AM;
      end
      ctrl_sig_pkg::T2_ABS_AM: begin
        if (dec.op != cpu_isa_pkg::OP_JMP)
          next_state = dec.is_store ? ctrl_sig_pkg::TX_W_DATA : ctrl_sig_pkg::TX_R_DATA;
      end
      ctrl_sig_pkg::TX_R_DATA: begin
        if (dec.is_rmw)
          next_state = ctrl_sig_pkg::TX_M_DATA;
      end
      ctrl_sig_pkg::TX_M_DATA: next_state = ctrl_sig_pkg::TX_W_DATA;
      default:                 next_state = ctrl_sig_pkg::T0_R_OPCO;
    endcase
  end

  a_state_legal: assert property (@(posedge CLK) disable iff (reset)
    state inside {ctrl_sig_pkg::T0_R_OPCO, ctrl_sig_pkg::T1_R_OPER,
                  ctrl_sig_pkg::T2_ABS_AM, ctrl_sig_pkg::TX_R_DATA,
                  ctrl_sig_pkg::TX_M_DATA, ctrl_sig_pkg::TX_W_DATA});

  // A stalled cycle must repeat on the next clock
  a_stall_hold: assert property (@(posedge CLK) disable iff (reset)
    !rdy |=> $stable(state));

endmodule

/* design/opcode_decoder.sv */
`timescale 1ns/10ps

module opcode_decoder (
  input  logic [7:0]                  instr,
  output cpu_isa_pkg::decoded_instr_t dec
);

  cpu_isa_pkg::op_t        op;
  cpu_isa_pkg::addr_mode_t mode;
  logic [2:0]              aaa;
  logic [2:0]              bbb;
  logic [1:0]              cc;

  // Standard aaabbbcc opcode layout
  assign aaa = instr[7:5];
  assign bbb = instr[4:2];
  assign cc  = instr[1:0];

  always_comb begin
    case (instr)
      8'hA9, 8'hA5, 8'hAD: op = cpu_isa_pkg::OP_LDA;
      8'hA2, 8'hA6, 8'hAE: op = cpu_isa_pkg::OP_LDX;
      8'hA0, 8'hA4, 8'hAC: op = cpu_isa_pkg::OP_LDY;
      8'h85, 8'h8D:        op = cpu_isa_pkg::OP_STA;
      8'h86, 8'h8E:        op = cpu_isa_pkg::OP_STX;
      8'h84, 8'h8C:        op = cpu_isa_pkg::OP_STY;
      8'hAA:               op = cpu_isa_pkg::OP_TAX;
      8'hA8:               op = cpu_isa_pkg::OP_TAY;
      8'h8A:               op = cpu_isa_pkg::OP_TXA;
      8'h98:               op = cpu_isa_pkg::OP_TYA;
      8'hBA:               op = cpu_isa_pkg::OP_TSX;
      8'h9A:               op = cpu_isa_pkg::OP_TXS;
      8'h69, 8'h65, 8'h6D: op = cpu_isa_pkg::OP_ADC;
      8'hE9, 8'hE5, 8'hED: op = cpu_isa_pkg::OP_SBC;
      8'h29, 8'h25, 8'h2D: op = cpu_isa_pkg::OP_AND;
      8'h09, 8'h05, 8'h0D: op = cpu_isa_pkg::OP_ORA;
      8'h49, 8'h45, 8'h4D: op = cpu_isa_pkg::OP_EOR;
      8'hC9, 8'hC5, 8'hCD: op = cpu_isa_pkg::OP_CMP;
      8'hE0, 8'hE4, 8'hEC: op = cpu_isa_pkg::OP_CPX;
      8'hC0, 8'hC4, 8'hCC: op = cpu_isa_pkg::OP_CPY;
      8'h24, 8'h2C:        op = cpu_isa_pkg::OP_BIT;
      8'hE8:               op = cpu_isa_pkg::OP_INX;
      8'hC8:               op = cpu_isa_pkg::OP_INY;
      8'hCA:               op = cpu_isa_pkg::OP_DEX;
      8'h88:               op = cpu_isa_pkg::OP_DEY;
      8'h0A, 8'h06, 8'h0E: op = cpu_isa_pkg::OP_ASL;
      8'h4A, 8'h46, 8'h4E: op = cpu_isa_pkg::OP_LSR;
      8'h2A, 8'h26, 8'h2E: op = cpu_isa_pkg::OP_ROL;
      8'h6A, 8'h66, 8'h6E: op = cpu_isa_pkg::OP_ROR;
      8'hE6, 8'hEE:        op = cpu_isa_pkg::OP_INC;
      8'hC6, 8'hCE:        op = cpu_isa_pkg::OP_DEC;
      8'h18:               op = cpu_isa_pkg::OP_CLC;
      8'h38:               op = cpu_isa_pkg::OP_SEC;
      8'hD8:               op = cpu_isa_pkg::OP_CLD;
      8'hF8:               op = cpu_isa_pkg::OP_SED;
      8'h58:               op = cpu_isa_pkg::OP_CLI;
      8'h78:               op = cpu_isa_pkg::OP_SEI;
      8'hB8:               op = cpu_isa_pkg::OP_CLV;
      8'h4C:               op = cpu_isa_pkg::OP_JMP;
      default:             op = cpu_isa_pkg::OP_NOP;
    endcase
  end

  // Mode from the bbb field, valid only for opcodes listed above
  always_comb begin
    case (bbb)
      3'b000: mode = cpu_isa_pkg::AM_IMM;
      3'b001: mode = cpu_isa_pkg::AM_ZPG;
      3'b011: mode = cpu_isa_pkg::AM_ABS;
      3'b010: begin
        if (cc == 2'b01)
          mode = cpu_isa_pkg::AM_IMM;
        else if (cc == 2'b10 && !aaa[2])
          mode = cpu_isa_pkg::AM_ACC;
        else
          mode = cpu_isa_pkg::AM_IMP;
      end
      default: mode = cpu_isa_pkg::AM_IMP;
    endcase
    if (op == cpu_isa_pkg::OP_NOP)
      mode = cpu_isa_pkg::AM_IMP;
  end

  assign dec.op          = op;
  assign dec.addr_mode   = mode;
  assign dec.is_load     = op inside {cpu_isa_pkg::OP_LDA, cpu_isa_pkg::OP_LDX,
                                      cpu_isa_pkg::OP_LDY};
  assign dec.is_store    = op inside {cpu_isa_pkg::OP_STA, cpu_isa_pkg::OP_STX,
                                      cpu_isa_pkg::OP_STY};
  assign dec.is_transfer = op inside {cpu_isa_pkg::OP_TAX, cpu_isa_pkg::OP_TAY,
                                      cpu_isa_pkg::OP_TXA, cpu_isa_pkg::OP_TYA,
                                      cpu_isa_pkg::OP_TSX, cpu_isa_pkg::OP_TXS};
  assign dec.is_rmw      = op inside {cpu_isa_pkg::OP_ASL, cpu_isa_pkg::OP_LSR,
                                      cpu_isa_pkg::OP_ROL, cpu_isa_pkg::OP_ROR,
                                      cpu_isa_pkg::OP_INC, cpu_isa_pkg::OP_DEC};
  assign dec.is_set      = op inside {cpu_isa_pkg::OP_SEC, cpu_isa_pkg::OP_SED,
                                      cpu_isa_pkg::OP_SEI};
  assign dec.is_clr      = op inside {cpu_isa_pkg::OP_CLC, cpu_isa_pkg::OP_CLD,
                                      cpu_isa_pkg::OP_CLI, cpu_isa_pkg::OP_CLV};

endmodule

/* design/ctrl_sig_pkg.sv */
package ctrl_sig_pkg;

  typedef enum logic [2:0] {
    T0_R_OPCO,
    T1_R_OPER,
    T2_ABS_AM,
    TX_R_DATA,
    TX_M_DATA,
    TX_W_DATA
  } state_t;

  // Same order as alu_src_a_t for the first five entries
  typedef enum logic [2:0] {REG_A, REG_X, REG_Y, REG_S, REG_T, REG_P} reg_sel_t;

  typedef enum logic [3:0] {
    ALU_THA, ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR, ALU_CMP,
    ALU_BIT, ALU_INC, ALU_DEC, ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR
  } alu_op_t;

  typedef enum logic [2:0] {SRC_A_A, SRC_A_X, SRC_A_Y, SRC_A_S, SRC_A_T} alu_src_a_t;
  typedef enum logic [0:0] {SRC_B_T} alu_src_b_t;
  typedef enum logic [0:0] {REG_SRC_MEM, REG_SRC_ALU} reg_src_t;
  typedef enum logic [1:0] {P_ALU, P_SET, P_CLR, P_NON} p_src_t;
  typedef enum logic [0:0] {PC_NOP, PC_INC} pc_add_t;
  typedef enum logic [0:0] {PCL_ADD, PCL_T} pcl_src_t;
  typedef enum logic [0:0] {PCH_ADD, PCH_MEM} pch_src_t;
  typedef enum logic [2:0] {AB_PCN, AB_PCC, AB_MEM, AB_T, AB_H00} ab_src_t;
  typedef enum logic [1:0] {DB_A, DB_X, DB_Y, DB_T} db_src_t;

  // Bus direction, high means read
  localparam logic RW_READ  = 1'b1;
  localparam logic RW_WRITE = 1'b0;

  typedef struct packed {
    logic    r_w;
    db_src_t db_out_src;
  } bus_ctrl_t;

  typedef struct packed {
    alu_op_t    alu_op;
    alu_src_a_t alu_src_a;
    alu_src_b_t alu_src_b;
  } alu_ctrl_t;

  typedef struct packed {
    reg_src_t   reg_src;
    logic       a_we;
    logic       x_we;
    logic       y_we;
    logic       s_we;
    logic       t_we;
    p_src_t     p_src;
    logic [7:0] p_mask;
  } reg_ctrl_t;

  typedef struct packed {
    pc_add_t  pc_add;
    pcl_src_t pcl_src;
    pch_src_t pch_src;
    logic     pcl_we;
    logic     pch_we;
  } pc_ctrl_t;

  typedef struct packed {
    ab_src_t abl_src;
    ab_src_t abh_src;
    logic    abl_we;
    logic    abh_we;
  } ab_ctrl_t;

endpackage

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

  // Operations of the supported subset, anything else decodes as NOP
  typedef enum logic [5:0] {
    OP_NOP,
    OP_LDA, OP_LDX, OP_LDY,
    OP_STA, OP_STX, OP_STY,
    OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS,
    OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
    OP_CMP, OP_CPX, OP_CPY, OP_BIT,
    OP_INX, OP_INY, OP_DEX, OP_DEY,
    OP_ASL, OP_LSR, OP_ROL, OP_ROR, OP_INC, OP_DEC,
    OP_CLC, OP_SEC, OP_CLD, OP_SED, OP_CLI, OP_SEI, OP_CLV,
    OP_JMP
  } op_t;

  typedef enum logic [2:0] {
    AM_IMP,
    AM_ACC,
    AM_IMM,
    AM_ZPG,
    AM_ABS
  } addr_mode_t;

  // Processor status bit positions
  localparam logic [7:0] FLAG_MASK_C = 8'h01;
  localparam logic [7:0] FLAG_MASK_Z = 8'h02;
  localparam logic [7:0] FLAG_MASK_I = 8'h04;
  localparam logic [7:0] FLAG_MASK_D = 8'h08;
  localparam logic [7:0] FLAG_MASK_V = 8'h40;
  localparam logic [7:0] FLAG_MASK_N = 8'h80;

  typedef struct packed {
    op_t        op;
    addr_mode_t addr_mode;
    logic       is_load;
    logic       is_store;
    logic       is_transfer;
    // Read-modify-write, ACC-mode shifts included
    logic       is_rmw;
    logic       is_set;
    logic       is_clr;
  } decoded_instr_t;

endpackage
